//--- include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Fetch address and instruction widths, in bits.
`define ICACHE_ADDR_W  32
`define ICACHE_WORD_W  32

// Sixteen one-word lines, so the tag is what is left of the address.
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W   (`ICACHE_ADDR_W - `ICACHE_INDEX_W)

`define ICACHE_CNT_W   16

`endif

//--- logic/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]  word_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_CNT_W-1:0]   cnt_t;  // Saturating statistics.

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } line_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic enable;
        logic flush;  // One-cycle pulse.
    } cfg_t;

    typedef enum logic [1:0] {IDLE, COMPARE, REFILL} ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_array (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               flush,
    input  wire icache_pkg::index_t lookup_index,
    output icache_pkg::line_t       lookup_line,
    input  wire logic               write_en,
    input  wire icache_pkg::index_t write_index,
    input  wire icache_pkg::line_t  write_line
);

    localparam int DEPTH = 1 << `ICACHE_INDEX_W;

    logic [DEPTH-1:0]  valid_q;
    icache_pkg::tag_t  tag_mem  [DEPTH];
    icache_pkg::word_t data_mem [DEPTH];

    // Valid bits, cleared in one cycle by reset or flush.
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid_q <= '0;  // Flush wins over a write.
        end
        else if (write_en)
        begin
            valid_q[write_index] <= write_line.valid;
        end
    end

    // Tag and data storage.
    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            tag_mem[write_index]  <= write_line.tag;
            data_mem[write_index] <= write_line.data;
        end
    end

    // Combinational lookup.
    always_comb
    begin
        lookup_line.valid = valid_q[lookup_index];
        lookup_line.tag   = tag_mem[lookup_index];
        lookup_line.data  = data_mem[lookup_index];
    end

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire icache_pkg::cfg_t   cfg,
    input  wire logic               cpu_req_valid,
    input  wire icache_pkg::addr_t  cpu_req_addr,
    output logic                    cpu_req_ready,
    output icache_pkg::word_t       cpu_req_data,
    output icache_pkg::mem_req_t    mem_req,
    input  wire logic               mem_resp_ready,
    input  wire icache_pkg::word_t  mem_resp_data,
    input  wire icache_pkg::line_t  lookup_line,
    output logic                    write_en,
    output icache_pkg::index_t      write_index,
    output icache_pkg::line_t       write_line,
    output logic                    hit_event,
    output logic                    miss_event
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    icache_pkg::tag_t req_tag;
    logic             tag_hit;
    logic             hit;
    logic             refill_done;

    assign req_tag     = cpu_req_addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W];
    assign tag_hit     = lookup_line.valid && (lookup_line.tag == req_tag);
    assign hit         = tag_hit && cfg.enable;  // Disabled means bypass.
    assign refill_done = (state_q == icache_pkg::REFILL) && mem_resp_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= icache_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE:
            begin
                if (cpu_req_valid)
                begin
                    state_d = icache_pkg::COMPARE;
                end
            end
            icache_pkg::COMPARE:
            begin
                if (hit)
                begin
                    state_d = icache_pkg::IDLE;
                end
                else
                begin
                    state_d = icache_pkg::REFILL;  // Miss or bypass.
                end
            end
            icache_pkg::REFILL:
            begin
                if (mem_resp_ready)
                begin
                    state_d = icache_pkg::IDLE;
                end
            end
            default: state_d = icache_pkg::IDLE;
        endcase
    end

    // Processor response, from the line on a hit, from memory on a refill.
    always_comb
    begin
        cpu_req_ready = ((state_q == icache_pkg::COMPARE) && hit) || refill_done;
        if (state_q == icache_pkg::COMPARE)
        begin
            cpu_req_data = lookup_line.data;
        end
        else
        begin
            cpu_req_data = mem_resp_data;
        end
    end

    // Memory request held for the whole refill.
    always_comb
    begin
        mem_req.valid = (state_q == icache_pkg::REFILL);
        mem_req.addr  = cpu_req_addr;
    end

    // Line fill, skipped in bypass and during a flush.
    always_comb
    begin
        write_en        = refill_done && cfg.enable && !cfg.flush;
        write_index     = cpu_req_addr[`ICACHE_INDEX_W-1:0];
        write_line.valid = 1'b1;
        write_line.tag   = req_tag;
        write_line.data  = mem_resp_data;
    end

    assign hit_event  = (state_q == icache_pkg::COMPARE) && hit;
    assign miss_event = (state_q == icache_pkg::COMPARE) && cfg.enable && !tag_hit;

endmodule

`default_nettype wire

//--- logic/icache_regs.sv
`timescale 1ns/1ps
`default_nettype none

module icache_regs (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              reg_wr,
    input  wire logic [1:0]        reg_addr,
    input  wire icache_pkg::word_t reg_wdata,
    output icache_pkg::word_t      reg_rdata,
    output icache_pkg::cfg_t       cfg,
    input  wire logic              hit_event,
    input  wire logic              miss_event
);

    logic             enable_q;
    logic             flush_q;
    icache_pkg::cnt_t hit_cnt_q;
    icache_pkg::cnt_t miss_cnt_q;

    // CTRL register and flush pulse.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end
        else
        begin
            flush_q <= reg_wr && (reg_addr == 2'd0) && reg_wdata[1];
            if (reg_wr && (reg_addr == 2'd0))
            begin
                enable_q <= reg_wdata[0];
            end
        end
    end

    // Statistics counters; a write clears and beats an increment.
    always_ff @(posedge clk)
    begin
        if (rst || (reg_wr && (reg_addr == 2'd1)))
        begin
            hit_cnt_q <= '0;
        end
        else if (hit_event && !(&hit_cnt_q))
        begin
            hit_cnt_q <= hit_cnt_q + 1'b1;
        end
        if (rst || (reg_wr && (reg_addr == 2'd2)))
        begin
            miss_cnt_q <= '0;
        end
        else if (miss_event && !(&miss_cnt_q))
        begin
            miss_cnt_q <= miss_cnt_q + 1'b1;
        end
    end

    always_comb
    begin
        cfg.enable = enable_q;
        cfg.flush  = flush_q;
        case (reg_addr)
            2'd0:    reg_rdata = icache_pkg::word_t'(enable_q);
            2'd1:    reg_rdata = icache_pkg::word_t'(hit_cnt_q);
            2'd2:    reg_rdata = icache_pkg::word_t'(miss_cnt_q);
            default: reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cpu_req_valid,
    input  wire icache_pkg::addr_t    cpu_req_addr,
    output icache_pkg::mem_req_t      mem_req,
    output logic                      cpu_req_ready,
    output icache_pkg::word_t         cpu_req_data,
    input  wire logic                 mem_resp_ready,
    input  wire icache_pkg::word_t    mem_resp_data,
    input  wire logic                 reg_wr,
    input  wire logic [1:0]           reg_addr,
    input  wire icache_pkg::word_t    reg_wdata,
    output icache_pkg::word_t         reg_rdata
);

    icache_pkg::cfg_t   cfg;
    icache_pkg::line_t  lookup_line;
    icache_pkg::line_t  write_line;
    icache_pkg::index_t write_index;
    logic               write_en;
    logic               hit_event;
    logic               miss_event;

    icache_ctrl i_icache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_data   (cpu_req_data),
        .mem_req        (mem_req),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_data  (mem_resp_data),
        .lookup_line    (lookup_line),
        .write_en       (write_en),
        .write_index    (write_index),
        .write_line     (write_line),
        .hit_event      (hit_event),
        .miss_event     (miss_event)
    );

    icache_array i_icache_array (
        .clk          (clk),
        .rst          (rst),
        .flush        (cfg.flush),
        .lookup_index (cpu_req_addr[`ICACHE_INDEX_W-1:0]),  // Low address bits.
        .lookup_line  (lookup_line),
        .write_en     (write_en),
        .write_index  (write_index),
        .write_line   (write_line)
    );

    icache_regs i_icache_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .cfg        (cfg),
        .hit_event  (hit_event),
        .miss_event (miss_event)
    );

endmodule

`default_nettype wire

//--- test/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module imem_model (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire icache_pkg::mem_req_t mem_req,
    output logic                      mem_resp_ready,
    output icache_pkg::word_t         mem_resp_data
);

    integer     seed = 32'hec3d_3143;
    logic       busy;
    logic [2:0] wait_cnt;

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_resp_ready <= 1'b0;
            mem_resp_data  <= '0;
            busy           <= 1'b0;
            wait_cnt       <= '0;
        end
        else
        begin
            mem_resp_ready <= 1'b0;
            if (busy)
            begin
                if (wait_cnt == 3'd0)
                begin
                    mem_resp_ready <= 1'b1;
                    mem_resp_data  <= mem_req.addr ^ 32'hc0de_0000;
                    busy           <= 1'b0;
                end
                else
                begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
            else if (mem_req.valid && !mem_resp_ready)
            begin
                busy     <= 1'b1;
                wait_cnt <= 3'($unsigned($random(seed)) % 32'd6);  // Latency 1 to 6.
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module tb_icache_top;

    localparam logic [1:0] OP_FETCH = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_READ  = 2'd2;
    localparam int DEPTH         = 1 << `ICACHE_INDEX_W;
    localparam int FETCH_TIMEOUT = 40;

    typedef struct packed {
        logic [1:0]        op;
        icache_pkg::addr_t addr;
        icache_pkg::word_t value;
    } step_t;

    logic                 clk;
    logic                 rst;
    logic                 cpu_req_valid;
    icache_pkg::addr_t    cpu_req_addr;
    logic                 cpu_req_ready;
    icache_pkg::word_t    cpu_req_data;
    icache_pkg::mem_req_t mem_req;
    logic                 mem_resp_ready;
    icache_pkg::word_t    mem_resp_data;
    logic                 reg_wr;
    logic [1:0]           reg_addr;
    icache_pkg::word_t    reg_wdata;
    icache_pkg::word_t    reg_rdata;

    step_t             steps[$];
    logic              model_valid [DEPTH];
    icache_pkg::tag_t  model_tag [DEPTH];
    logic              model_enable;
    icache_pkg::word_t model_hits;
    icache_pkg::word_t model_misses;
    int                fetch_count;
    logic              mem_valid_prev;

    icache_top i_icache_top (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .mem_req        (mem_req),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_req_data   (cpu_req_data),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_data  (mem_resp_data),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata)
    );

    imem_model i_imem_model (
        .clk            (clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_data  (mem_resp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory fetches counted on rising mem_req.valid.
    always @(negedge clk)
    begin
        if (rst)
        begin
            fetch_count    = 0;
            mem_valid_prev = 1'b0;
        end
        else
        begin
            if (mem_req.valid && !mem_valid_prev)
            begin
                fetch_count = fetch_count + 1;
            end
            mem_valid_prev = mem_req.valid;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopping at first error.");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s.", what);
        $display("TEST FAILED");
        $fatal(1, "Stopping on timeout.");
    endtask

    task automatic add_step(input logic [1:0] op, input icache_pkg::addr_t addr,
                            input icache_pkg::word_t value);
        step_t s;
        s.op    = op;
        s.addr  = addr;
        s.value = value;
        steps.push_back(s);
    endtask

    task automatic run_fetch(input icache_pkg::addr_t addr);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tag;
        logic               hit;
        int                 cycles;
        int                 fetches_before;
        idx            = addr[`ICACHE_INDEX_W-1:0];
        tag            = addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W];
        hit            = model_enable && model_valid[idx] && (model_tag[idx] == tag);
        fetches_before = fetch_count;
        cycles         = 0;
        @(posedge clk);
        cpu_req_valid <= 1'b1;
        cpu_req_addr  <= addr;
        do
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        while (!cpu_req_ready && (cycles < FETCH_TIMEOUT));
        if (!cpu_req_ready)
        begin
            report_timeout("cpu_req_ready");
        end
        else
        begin
            check_value("cpu_req_data", cpu_req_data, addr ^ 32'hc0de_0000);
            if (hit)
            begin
                check_value("hit latency", cycles, 2);  // Cycles from request to ready.
            end
            @(posedge clk);
            cpu_req_valid <= 1'b0;
            check_value("memory fetches", fetch_count, fetches_before + (hit ? 0 : 1));
            if (hit)
            begin
                model_hits = model_hits + 1;
            end
            else if (model_enable)
            begin
                model_misses     = model_misses + 1;
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
            end
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input icache_pkg::word_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
        case (addr)
            2'd0:
            begin
                model_enable = data[0];
                if (data[1])
                begin
                    foreach (model_valid[i])
                    begin
                        model_valid[i] = 1'b0;
                    end
                end
            end
            2'd1:    model_hits = '0;
            2'd2:    model_misses = '0;
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [1:0] addr);
        icache_pkg::word_t expected;
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        case (addr)
            2'd0:    expected = {31'b0, model_enable};
            2'd1:    expected = model_hits;
            2'd2:    expected = model_misses;
            default: expected = '0;
        endcase
        check_value("reg_rdata", reg_rdata, expected);
    endtask

    task automatic build_table();
        // Miss then hit on one address.
        add_step(OP_FETCH, 32'h0000_1234, '0);
        add_step(OP_FETCH, 32'h0000_1234, '0);
        // Same index, different tags.
        add_step(OP_FETCH, 32'h0000_1005, '0);
        add_step(OP_FETCH, 32'h0000_2005, '0);
        add_step(OP_FETCH, 32'h0000_1005, '0);
        add_step(OP_FETCH, 32'h0000_2005, '0);
        add_step(OP_FETCH, 32'h0000_300a, '0);
        add_step(OP_FETCH, 32'h0000_400b, '0);
        add_step(OP_FETCH, 32'h0000_300a, '0);
        add_step(OP_FETCH, 32'h0000_400b, '0);
        add_step(OP_FETCH, 32'h0000_2005, '0);
        add_step(OP_READ,  32'd1, '0);
        add_step(OP_READ,  32'd2, '0);
        // Flush with enable kept.
        add_step(OP_WRITE, 32'd0, 32'h0000_0003);
        add_step(OP_FETCH, 32'h0000_300a, '0);
        add_step(OP_FETCH, 32'h0000_400b, '0);
        add_step(OP_FETCH, 32'h0000_2005, '0);
        add_step(OP_FETCH, 32'h0000_1234, '0);
        // Bypass.
        add_step(OP_WRITE, 32'd0, 32'h0000_0000);
        add_step(OP_READ,  32'd0, '0);
        add_step(OP_FETCH, 32'h0000_5006, '0);
        add_step(OP_FETCH, 32'h0000_5006, '0);
        add_step(OP_FETCH, 32'h0000_300a, '0);
        add_step(OP_READ,  32'd1, '0);
        add_step(OP_READ,  32'd2, '0);
        add_step(OP_WRITE, 32'd0, 32'h0000_0001);
        add_step(OP_FETCH, 32'h0000_5006, '0);
        add_step(OP_FETCH, 32'h0000_5006, '0);
        add_step(OP_FETCH, 32'h0000_300a, '0);
        // Counters read back and cleared.
        add_step(OP_READ,  32'd1, '0);
        add_step(OP_READ,  32'd2, '0);
        add_step(OP_WRITE, 32'd1, '0);
        add_step(OP_WRITE, 32'd2, '0);
        add_step(OP_READ,  32'd1, '0);
        add_step(OP_READ,  32'd2, '0);
        add_step(OP_READ,  32'd0, '0);
    endtask

    initial
    begin
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr  = '0;
        reg_wr        = 1'b0;
        reg_addr      = 2'd0;
        reg_wdata     = '0;
        foreach (model_valid[i])
        begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        model_enable = 1'b1;
        model_hits   = '0;
        model_misses = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i])
        begin
            case (steps[i].op)
                OP_FETCH: run_fetch(steps[i].addr);
                OP_WRITE: write_reg(steps[i].addr[1:0], steps[i].value);
                default:  read_reg(steps[i].addr[1:0]);
            endcase
        end
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
logic/icache_pkg.sv
logic/icache_array.sv
logic/icache_ctrl.sv
logic/icache_regs.sv
logic/icache_top.sv
test/imem_model.sv
test/tb_icache_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_icache_top
FILELIST  := compile.f
BUILD_DIR := obj_dir

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(BUILD_DIR)
